// ==== tlu_trigger_patterns.txt ====
# name mode fmt threshold timeout pulse_len veto set set_value(hex) pulses words errors ts_reset
# mode and fmt are 2-bit codes, pulse_len in cycles, words and errors are totals for the line
cnt_basic       0 0 0  0  1 0 0 00000000 4 4 0 0
cnt_long        1 0 0  0  6 0 0 00000000 2 2 0 0
cnt_set         0 0 0  0  2 0 1 00001234 3 3 0 0
cnt_set_wrap    0 3 0  0  2 0 1 7ffffffe 3 3 0 0
thr_long        0 0 6  0 10 0 0 00000000 2 2 0 0
thr_short       0 0 6  0  4 0 0 00000000 2 0 0 0
thr_one         1 0 1  0  5 0 0 00000000 2 2 0 0
veto_edge       0 0 0  0  3 1 0 00000000 2 0 0 0
veto_thr        0 0 6  0 10 1 0 00000000 2 0 0 0
ts_run          0 1 0  0  2 0 0 00000000 3 3 0 0
ts_reset        0 1 0  0  2 0 0 00000000 2 2 0 1
comb_run        0 2 0  0  2 0 0 00000000 3 3 0 0
comb_reset      1 2 0  0  2 0 0 00000000 2 2 0 1
tlu_hs          2 0 0  0  5 0 0 00000000 4 4 0 0
tlu_hs_comb     2 2 0  0  8 0 0 00000000 2 2 0 0
tlu_timeout     2 0 0 10 40 0 0 00000000 2 2 2 0
tlu_no_timeout  2 0 0 10  3 0 0 00000000 2 2 0 0
reserved_mode   3 0 0  0  4 0 0 00000000 3 0 0 0
reserved_thr    3 0 6  0 10 0 0 00000000 2 0 0 0

// ==== sim.f ====
+incdir+.
tlu_trigger_pkg.sv
trigger_qualifier.sv
trigger_handshake_fsm.sv
trigger_word_builder.sv
tlu_trigger_top.sv
tb_tlu_trigger.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_tlu_trigger
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_tlu_trigger.sv ====
// ----------------------------------------------------------
// self-checking testbench for the TLU trigger controller
// test lines come from tlu_trigger_patterns.txt, read from
// the directory the simulation runs in
// acknowledge delays come from an LFSR with a fixed seed
// ----------------------------------------------------------
`default_nettype none
`include "tlu_trigger_params.svh"

module tb_tlu_trigger;
    timeunit 1ns;
    timeprecision 100ps;
    import tlu_trigger_pkg::*;

    logic                      trigger_clk = 1'b0;
    logic                      reset;
    logic                      trigger;
    logic                      trigger_enable;
    logic                      trigger_veto;
    trigger_mode_e             trigger_mode;
    logic [`TLU_THRESH_W-1:0]  trigger_threshold;
    logic [`TLU_TIMEOUT_W-1:0] low_time_out;
    logic                      trigger_acknowledge;
    logic                      fifo_acknowledge;
    logic                      tlu_reset_flag;
    logic                      trigger_counter_set;
    tlu_word_t                 trigger_counter_set_value;
    data_format_e              data_format;
    tlu_word_t                 trigger_data;
    logic                      trigger_data_write;
    logic                      trigger_accepted_flag;
    logic                      tlu_busy;
    logic                      fifo_preempt_req;
    logic                      low_timeout_error_flag;

    string        cur_name = "reset";
    data_format_e cur_fmt = FMT_COUNTER;
    tlu_word_t    model_counter = '0;
    tlu_word_t    prev_ts;
    logic         have_prev_ts = 1'b0;
    logic         ts_was_reset = 1'b0;
    logic [31:0]  lfsr_state = 32'hf4bf_8cb8;
    tlu_word_t    word_queue[$];
    int           write_count = 0;
    int           accept_count = 0;
    int           error_count = 0;
    int           busy_cycles = 0;

    // fields of the current pattern line
    int        p_mode, p_fmt, p_thresh, p_timeout, p_len, p_veto, p_set;
    int        p_pulses, p_words, p_errors, p_tsreset;
    tlu_word_t p_setval;

    tlu_trigger_top tlu_trigger_top_i (
        .trigger_clk               (trigger_clk),
        .reset                     (reset),
        .trigger                   (trigger),
        .trigger_enable            (trigger_enable),
        .trigger_veto              (trigger_veto),
        .trigger_mode              (trigger_mode),
        .trigger_threshold         (trigger_threshold),
        .low_time_out              (low_time_out),
        .trigger_acknowledge       (trigger_acknowledge),
        .fifo_acknowledge          (fifo_acknowledge),
        .tlu_reset_flag            (tlu_reset_flag),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .data_format               (data_format),
        .trigger_data              (trigger_data),
        .trigger_data_write        (trigger_data_write),
        .trigger_accepted_flag     (trigger_accepted_flag),
        .tlu_busy                  (tlu_busy),
        .fifo_preempt_req          (fifo_preempt_req),
        .low_timeout_error_flag    (low_timeout_error_flag)
    );

    always #4 trigger_clk = ~trigger_clk;

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR in %s: %s", cur_name, reason);
        fail_run();
    endtask

    task automatic check_word(input string what, input tlu_word_t expected,
                              input tlu_word_t actual);
        if (expected !== actual)
        begin
            $display("FAIL %s %s: expected %h, actual %h", cur_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("FAIL %s %s: expected %b, actual %b", cur_name, what, expected, actual);
            fail_run();
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic int random_bits(input int count);
        int value;
        int i;
        value = 0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // outputs sampled before the edge updates them
    always @(posedge trigger_clk)
    begin
        if (!reset)
        begin
            if (trigger_data_write)
            begin
                word_queue.push_back(trigger_data);
                write_count <= write_count + 1;
            end
            if (low_timeout_error_flag)
                error_count <= error_count + 1;
            if (tlu_busy)
                busy_cycles <= busy_cycles + 1;
            if (trigger_accepted_flag)
            begin
                accept_count <= accept_count + 1;
                check_flag("busy_with_accept", 1'b1, tlu_busy);
                check_flag("preempt_with_accept", 1'b1, fifo_preempt_req);
            end
        end
    end

    task automatic check_timestamp(input tlu_word_t ts);
        if (have_prev_ts && ts_was_reset)
            check_flag("ts_lower_after_reset", 1'b1, ts < prev_ts);
        else if (have_prev_ts)
            check_flag("ts_increasing", 1'b1, ts > prev_ts);
        prev_ts      = ts;
        have_prev_ts = 1'b1;
        ts_was_reset = 1'b0;
    endtask

    task automatic check_new_word();
        tlu_word_t w;
        w = word_queue.pop_front();
        check_flag("header_bit", 1'b1, w[31]);
        case (cur_fmt)
            FMT_TIMESTAMP:
                check_timestamp({1'b0, w[30:0]});
            FMT_COMBINED:
            begin
                check_timestamp({17'b0, w[30:16]}); // only 15 timestamp bits in the word
                check_word("counter_low", {16'b0, model_counter[15:0]}, {16'b0, w[15:0]});
            end
            default:
                check_word("counter_word", {1'b1, model_counter[30:0]}, w);
        endcase
        model_counter = model_counter + 1;
    endtask

    task automatic hold_busy_cycle();
        @(posedge trigger_clk);
        check_flag("busy_held", 1'b1, tlu_busy);
        check_flag("preempt_held", 1'b1, fifo_preempt_req);
    endtask

    task automatic release_fsm();
        int d_trig;
        int d_fifo;
        int i;
        int waited;
        d_trig = random_bits(4);
        d_fifo = random_bits(4);
        for (i = 0; i < d_trig; i++)
            hold_busy_cycle();
        trigger_acknowledge <= 1'b1;
        for (i = 0; i < d_fifo; i++)
            hold_busy_cycle();
        fifo_acknowledge <= 1'b1;
        waited = 0;
        @(posedge trigger_clk);
        while (tlu_busy)
        begin
            if (waited == 4)
                abort_run("busy did not fall within 4 cycles of both acknowledges");
            else
            begin
                @(posedge trigger_clk);
                waited++;
            end
        end
        check_flag("preempt_released", 1'b0, fifo_preempt_req);
        trigger_acknowledge <= 1'b0;
        fifo_acknowledge    <= 1'b0;
    endtask

    task automatic fire_pulse(input int len, input logic expect_word);
        int start_writes;
        int waited;
        int i;
        start_writes = write_count;
        trigger <= 1'b1;
        for (i = 0; i < len; i++)
            @(posedge trigger_clk);
        trigger <= 1'b0;
        if (expect_word)
        begin
            waited = 0;
            while (write_count == start_writes)
            begin
                if (waited == 100)
                    abort_run("no data word was written for the trigger");
                else
                begin
                    @(posedge trigger_clk);
                    waited++;
                end
            end
            check_new_word();
            release_fsm();
        end
        else
            repeat (12) @(posedge trigger_clk); // window where a word would have shown up
        repeat (2) @(posedge trigger_clk);
    endtask

    task automatic run_line();
        int start_writes;
        int start_accepts;
        int start_errors;
        int start_busy;
        int n;
        if (data_format_e'(p_fmt[1:0]) != cur_fmt)
            have_prev_ts = 1'b0;
        cur_fmt = data_format_e'(p_fmt[1:0]);
        trigger_mode      <= trigger_mode_e'(p_mode[1:0]);
        data_format       <= cur_fmt;
        trigger_threshold <= p_thresh[`TLU_THRESH_W-1:0];
        low_time_out      <= p_timeout[`TLU_TIMEOUT_W-1:0];
        trigger_veto      <= p_veto[0];
        if (p_set != 0)
        begin
            trigger_counter_set       <= 1'b1;
            trigger_counter_set_value <= p_setval;
            model_counter = p_setval;
        end
        if (p_tsreset != 0)
        begin
            tlu_reset_flag <= 1'b1;
            ts_was_reset = 1'b1;
        end
        @(posedge trigger_clk);
        trigger_counter_set <= 1'b0;
        tlu_reset_flag      <= 1'b0;
        @(posedge trigger_clk);
        start_writes  = write_count;
        start_accepts = accept_count;
        start_errors  = error_count;
        start_busy    = busy_cycles;
        for (n = 0; n < p_pulses; n++)
            fire_pulse(p_len, p_words != 0);
        check_word("word_count", tlu_word_t'(p_words), tlu_word_t'(write_count - start_writes));
        check_word("accept_count", tlu_word_t'(p_words),
                   tlu_word_t'(accept_count - start_accepts));
        check_word("timeout_errors", tlu_word_t'(p_errors),
                   tlu_word_t'(error_count - start_errors));
        if (p_words == 0)
            check_word("busy_cycles", '0, tlu_word_t'(busy_cycles - start_busy));
    endtask

    initial
    begin
        int    fd;
        int    code;
        int    fields;
        int    lines_run;
        string line;
        reset                     <= 1'b1;
        trigger                   <= 1'b0;
        trigger_enable            <= 1'b1;
        trigger_veto              <= 1'b0;
        trigger_mode              <= MODE_SIMPLE;
        trigger_threshold         <= '0;
        low_time_out              <= '0;
        trigger_acknowledge       <= 1'b0;
        fifo_acknowledge          <= 1'b0;
        tlu_reset_flag            <= 1'b0;
        trigger_counter_set       <= 1'b0;
        trigger_counter_set_value <= '0;
        data_format               <= FMT_COUNTER;
        lines_run = 0;
        repeat (5) @(posedge trigger_clk);
        reset <= 1'b0;
        @(posedge trigger_clk);
        check_flag("busy_after_reset", 1'b0, tlu_busy);
        check_flag("write_after_reset", 1'b0, trigger_data_write);
        fd = $fopen("tlu_trigger_patterns.txt", "r");
        if (fd == 0)
            abort_run("cannot open tlu_trigger_patterns.txt");
        while (!$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#")
            begin
                fields = $sscanf(line, "%s %d %d %d %d %d %d %d %h %d %d %d %d", cur_name,
                                 p_mode, p_fmt, p_thresh, p_timeout, p_len, p_veto, p_set,
                                 p_setval, p_pulses, p_words, p_errors, p_tsreset);
                if (fields != 13)
                    abort_run("pattern line does not have 13 fields");
                else
                begin
                    run_line();
                    lines_run++;
                end
            end
        end
        $fclose(fd);
        if (lines_run == 0)
            abort_run("no test lines found in the pattern file");
        else
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tlu_trigger_top.sv ====
// ----------------------------------------------------------
// TLU trigger controller, all ports on trigger_clk
// reset is synchronous and active high
// mode 2'b11 ignores the trigger input
// ----------------------------------------------------------
`default_nettype none
`include "tlu_trigger_params.svh"

module tlu_trigger_top (
    input  logic                           trigger_clk,
    input  logic                           reset,
    input  logic                           trigger,
    input  logic                           trigger_enable,
    input  logic                           trigger_veto,
    input  tlu_trigger_pkg::trigger_mode_e trigger_mode,
    input  logic [`TLU_THRESH_W-1:0]       trigger_threshold,
    input  logic [`TLU_TIMEOUT_W-1:0]      low_time_out,
    input  logic                           trigger_acknowledge,
    input  logic                           fifo_acknowledge,
    input  logic                           tlu_reset_flag,
    input  logic                           trigger_counter_set,
    input  tlu_trigger_pkg::tlu_word_t     trigger_counter_set_value,
    input  tlu_trigger_pkg::data_format_e  data_format,
    output tlu_trigger_pkg::tlu_word_t     trigger_data,
    output logic                           trigger_data_write,
    output logic                           trigger_accepted_flag,
    output logic                           tlu_busy,
    output logic                           fifo_preempt_req,
    output logic                           low_timeout_error_flag
);

    logic simple_start;
    logic tlu_start;
    logic fsm_idle;
    logic latch_pulse;

    trigger_qualifier trigger_qualifier_i (
        .trigger_clk       (trigger_clk),
        .reset             (reset),
        .trigger           (trigger),
        .trigger_enable    (trigger_enable),
        .trigger_veto      (trigger_veto),
        .trigger_mode      (trigger_mode),
        .trigger_threshold (trigger_threshold),
        .fsm_idle          (fsm_idle),
        .simple_start      (simple_start),
        .tlu_start         (tlu_start)
    );

    trigger_handshake_fsm trigger_handshake_fsm_i (
        .trigger_clk            (trigger_clk),
        .reset                  (reset),
        .trigger                (trigger),
        .trigger_mode           (trigger_mode),
        .simple_start           (simple_start),
        .tlu_start              (tlu_start),
        .trigger_acknowledge    (trigger_acknowledge),
        .fifo_acknowledge       (fifo_acknowledge),
        .low_time_out           (low_time_out),
        .fsm_idle               (fsm_idle),
        .accept_pulse           (trigger_accepted_flag), // also feeds the word builder
        .latch_pulse            (latch_pulse),
        .tlu_busy               (tlu_busy),
        .fifo_preempt_req       (fifo_preempt_req),
        .low_timeout_error_flag (low_timeout_error_flag)
    );

    trigger_word_builder trigger_word_builder_i (
        .trigger_clk               (trigger_clk),
        .reset                     (reset),
        .accept_pulse              (trigger_accepted_flag),
        .latch_pulse               (latch_pulse),
        .tlu_reset_flag            (tlu_reset_flag),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .data_format               (data_format),
        .trigger_data              (trigger_data),
        .trigger_data_write        (trigger_data_write)
    );

endmodule

`default_nettype wire

// ==== trigger_word_builder.sv ====
// ----------------------------------------------------------
// timestamp runs every cycle and wraps at 32 bits
// the word carries the counter value from before the accept
// bit 31 of every output word is set
// ----------------------------------------------------------
`default_nettype none
`include "tlu_trigger_params.svh"

module trigger_word_builder (
    input  logic                          trigger_clk,
    input  logic                          reset,
    input  logic                          accept_pulse,
    input  logic                          latch_pulse,
    input  logic                          tlu_reset_flag,
    input  logic                          trigger_counter_set,
    input  tlu_trigger_pkg::tlu_word_t    trigger_counter_set_value,
    input  tlu_trigger_pkg::data_format_e data_format,
    output tlu_trigger_pkg::tlu_word_t    trigger_data,
    output logic                          trigger_data_write
);
    import tlu_trigger_pkg::*;

    tlu_word_t timestamp;
    tlu_word_t trigger_counter;
    tlu_word_t timestamp_capture;
    tlu_word_t counter_capture;
    tlu_word_t word;

    always_ff @(posedge trigger_clk)
    begin
        if (reset || tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            trigger_counter <= '0;
        else if (trigger_counter_set)
            trigger_counter <= trigger_counter_set_value; // set wins over increment
        else if (accept_pulse)
            trigger_counter <= trigger_counter + 1'b1;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (accept_pulse)
        begin
            timestamp_capture <= timestamp;
            counter_capture   <= trigger_counter;
        end
    end

    always_comb
    begin
        case (data_format)
            FMT_TIMESTAMP:
                word = {1'b1, timestamp_capture[`TLU_WORD_W-2:0]};
            FMT_COMBINED:
                word = {1'b1, timestamp_capture[`TLU_COMBINED_TS_BITS-1:0],
                        counter_capture[`TLU_COMBINED_CNT_BITS-1:0]};
            default:
                word = {1'b1, counter_capture[`TLU_WORD_W-2:0]}; // counter and reserved
        endcase
    end

    always_ff @(posedge trigger_clk)
    begin
        if (latch_pulse)
            trigger_data <= word;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            trigger_data_write <= 1'b0;
        else
            trigger_data_write <= latch_pulse;
    end

    header_bit_set: assert property (@(posedge trigger_clk) disable iff (reset)
        trigger_data_write |-> trigger_data[`TLU_WORD_W-1])
        else $error("data word written without bit 31");

endmodule

`default_nettype wire

// ==== trigger_handshake_fsm.sv ====
// ----------------------------------------------------------
// one trigger in flight at a time
// busy and preempt stay high until both acknowledges are seen
// low timeout of 0 waits for trigger low without limit
// a new trigger is taken only while both acknowledges are low
// ----------------------------------------------------------
`default_nettype none
`include "tlu_trigger_params.svh"

module trigger_handshake_fsm (
    input  logic                           trigger_clk,
    input  logic                           reset,
    input  logic                           trigger,
    input  tlu_trigger_pkg::trigger_mode_e trigger_mode,
    input  logic                           simple_start,
    input  logic                           tlu_start,
    input  logic                           trigger_acknowledge,
    input  logic                           fifo_acknowledge,
    input  logic [`TLU_TIMEOUT_W-1:0]      low_time_out,
    output logic                           fsm_idle,
    output logic                           accept_pulse,
    output logic                           latch_pulse,
    output logic                           tlu_busy,
    output logic                           fifo_preempt_req,
    output logic                           low_timeout_error_flag
);
    import tlu_trigger_pkg::*;

    handshake_state_e          state;
    handshake_state_e          next_state;
    logic [`TLU_TIMEOUT_W-1:0] low_count;
    logic                      timeout_hit;
    logic                      timeout_level;
    logic                      timeout_level_q;
    logic                      trigger_acked;
    logic                      fifo_acked;
    logic                      acks_low;

    assign fsm_idle    = (state == IDLE);
    assign acks_low    = !trigger_acknowledge && !fifo_acknowledge;
    assign timeout_hit = (low_time_out != '0) && (low_count >= low_time_out);

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (acks_low && simple_start)
                    next_state = SEND_COMMAND;
                else if (acks_low && tlu_start)
                    next_state = WAIT_FOR_TRIGGER_LOW;
            end
            SEND_COMMAND:
                next_state = LATCH_DATA; // no wait on trigger low in simple mode
            WAIT_FOR_TRIGGER_LOW:
            begin
                // a mode change also releases the wait
                if (!trigger || timeout_hit || trigger_mode != MODE_TLU_HANDSHAKE)
                    next_state = LATCH_DATA;
            end
            LATCH_DATA:
                next_state = WAIT_FOR_ACK;
            WAIT_FOR_ACK:
            begin
                if (trigger_acked && fifo_acked)
                    next_state = IDLE;
            end
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
        begin
            state            <= IDLE;
            accept_pulse     <= 1'b0;
            latch_pulse      <= 1'b0;
            tlu_busy         <= 1'b0;
            fifo_preempt_req <= 1'b0;
            trigger_acked    <= 1'b0;
            fifo_acked       <= 1'b0;
        end
        else
        begin
            state            <= next_state;
            accept_pulse     <= (state == IDLE) && (next_state != IDLE);
            latch_pulse      <= (state == LATCH_DATA);
            tlu_busy         <= (next_state != IDLE);
            fifo_preempt_req <= (next_state != IDLE);
            if (state == IDLE)
            begin
                trigger_acked <= 1'b0;
                fifo_acked    <= 1'b0;
            end
            else
            begin
                trigger_acked <= trigger_acked | trigger_acknowledge; // sticky until idle
                fifo_acked    <= fifo_acked | fifo_acknowledge;
            end
        end
    end

    // cycles spent waiting for the TLU trigger to fall
    always_ff @(posedge trigger_clk)
    begin
        if (reset || state != WAIT_FOR_TRIGGER_LOW)
            low_count <= '0;
        else if (low_count != '1)
            low_count <= low_count + 1'b1;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
        begin
            timeout_level   <= 1'b0;
            timeout_level_q <= 1'b0;
        end
        else
        begin
            if (state == IDLE)
                timeout_level <= 1'b0;
            else if (state == WAIT_FOR_TRIGGER_LOW && trigger && timeout_hit)
                timeout_level <= 1'b1;
            timeout_level_q <= timeout_level;
        end
    end

    assign low_timeout_error_flag = timeout_level & ~timeout_level_q; // one pulse per trigger

    accept_single: assert property (@(posedge trigger_clk) disable iff (reset)
        accept_pulse |=> !accept_pulse)
        else $error("accept pulse longer than one cycle");

    busy_low_in_idle: assert property (@(posedge trigger_clk) disable iff (reset)
        (state == IDLE) |-> !tlu_busy)
        else $error("busy high in state %s", state.name());

    no_latch_in_idle: assert property (@(posedge trigger_clk) disable iff (reset)
        (state == IDLE) |-> !latch_pulse)
        else $error("latch pulse while idle");

endmodule

`default_nettype wire

// ==== trigger_qualifier.sv ====
// ----------------------------------------------------------
// trigger input must already be synchronous to trigger_clk
// threshold 0 accepts on the rising edge alone
// threshold T accepts a pulse held high for T cycles or more
// starts are only issued while the FSM reports idle
// ----------------------------------------------------------
`default_nettype none
`include "tlu_trigger_params.svh"

module trigger_qualifier (
    input  logic                           trigger_clk,
    input  logic                           reset,
    input  logic                           trigger,
    input  logic                           trigger_enable,
    input  logic                           trigger_veto,
    input  tlu_trigger_pkg::trigger_mode_e trigger_mode,
    input  logic [`TLU_THRESH_W-1:0]       trigger_threshold,
    input  logic                           fsm_idle,
    output logic                           simple_start,
    output logic                           tlu_start
);
    import tlu_trigger_pkg::*;

    logic                     trigger_q;
    logic                     enable_q;
    logic [`TLU_THRESH_W-1:0] high_count;
    logic                     threshold_hit;
    logic                     trigger_rise;
    logic                     enable_rise;
    logic                     simple_mode;
    logic                     simple_qualified;

    assign trigger_rise = trigger & ~trigger_q;
    assign enable_rise  = trigger_enable & ~enable_q;
    assign simple_mode  = (trigger_mode == MODE_SIMPLE) || (trigger_mode == MODE_SIMPLE_ALT);

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
        begin
            trigger_q <= 1'b0;
            enable_q  <= 1'b0;
        end
        else
        begin
            trigger_q <= trigger;
            enable_q  <= trigger_enable;
        end
    end

    // high-time counter, starts only on a fresh edge and saturates
    always_ff @(posedge trigger_clk)
    begin
        if (reset || !trigger || !fsm_idle)
            high_count <= '0;
        else if (trigger_rise)
            high_count <= `TLU_THRESH_W'(1);
        else if (high_count != '0 && high_count != '1)
            high_count <= high_count + 1'b1;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            threshold_hit <= 1'b0;
        else
            threshold_hit <= (trigger_threshold != '0) && (high_count == trigger_threshold);
    end

    assign simple_qualified = (trigger_threshold == '0) ? trigger_rise : threshold_hit;

    assign simple_start = fsm_idle && trigger_enable && !trigger_veto && simple_mode
                          && simple_qualified;

    // a TLU already holding trigger high when enabled still counts
    assign tlu_start = fsm_idle && trigger_enable && (trigger_mode == MODE_TLU_HANDSHAKE)
                       && (trigger_rise || (trigger && enable_rise));

    start_exclusive: assert property (@(posedge trigger_clk) disable iff (reset)
        !(simple_start && tlu_start))
        else $error("simple and TLU start pulses overlap");

endmodule

`default_nettype wire

// ==== tlu_trigger_pkg.sv ====
// ----------------------------------------------------------
// types shared by the trigger controller and its testbench
// mode 2'b11 is reserved and never produces a trigger
// ----------------------------------------------------------
`default_nettype none
`include "tlu_trigger_params.svh"

package tlu_trigger_pkg;

    typedef logic [`TLU_WORD_W-1:0] tlu_word_t; // data word or counter value

    typedef enum logic [1:0] {
        MODE_SIMPLE        = 2'b00,
        MODE_SIMPLE_ALT    = 2'b01,
        MODE_TLU_HANDSHAKE = 2'b10,
        MODE_RESERVED      = 2'b11
    } trigger_mode_e;

    // reserved format falls back to the counter word
    typedef enum logic [1:0] {
        FMT_COUNTER   = 2'b00,
        FMT_TIMESTAMP = 2'b01,
        FMT_COMBINED  = 2'b10,
        FMT_RESERVED  = 2'b11
    } data_format_e;

    typedef enum logic [2:0] {
        IDLE                 = 3'd0,
        SEND_COMMAND         = 3'd1,
        WAIT_FOR_TRIGGER_LOW = 3'd2,
        LATCH_DATA           = 3'd3,
        WAIT_FOR_ACK         = 3'd4
    } handshake_state_e;

endpackage

`default_nettype wire

// ==== tlu_trigger_params.svh ====
// ----------------------------------------------------------
// fixed widths of the trigger controller
// the output word layout depends on these values, so they
// are not meant to be changed per instance
// ----------------------------------------------------------
`ifndef TLU_TRIGGER_PARAMS_SVH
`define TLU_TRIGGER_PARAMS_SVH

// data word, timestamp and trigger counter
`define TLU_WORD_W 32

// high-time threshold and its counter
`define TLU_THRESH_W 8

// low-timeout setting and its counter
`define TLU_TIMEOUT_W 8

`define TLU_COMBINED_TS_BITS 15  // timestamp bits in 30:16 of a combined word
`define TLU_COMBINED_CNT_BITS 16 // counter bits in 15:0 of a combined word

`endif
